// ==== Bender.yml ====
package:
  name: l1_cache

sources:
  - files:
      - design/cache_geom_pkg.sv
      - design/cache_ctrl_pkg.sv
      - design/cache_controller.sv
      - design/tag_store.sv
      - design/data_store.sv
      - design/l1_cache.sv
  - target: test
    files:
      - test/cache_checker.sv
      - test/tb_l1_cache.sv

// ==== design/cache_controller.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_controller #(
	parameter int ADDR_W = cache_geom_pkg::addr_width_default,
	parameter int DATA_W = cache_geom_pkg::data_width_default,
	parameter int INDEX_W = cache_geom_pkg::index_width_default
) (
	input wire clk,
	input wire rst,

	// CPU side.
	input wire cpu_req,
	input wire cpu_we,
	input wire [ADDR_W-1:0] cpu_addr,
	input wire [DATA_W-1:0] cpu_wdata,
	output logic cpu_ack,

	// DRAM side.
	output logic mem_req,
	output logic mem_we,
	output logic [ADDR_W-1:0] mem_addr,
	output logic [DATA_W-1:0] mem_wdata,
	input wire mem_ack,
	input wire [DATA_W-1:0] mem_rdata,

	// Tag store and data store.
	input wire hit,
	input wire victim_dirty,
	input wire [ADDR_W-INDEX_W-1:0] victim_tag,
	input wire [DATA_W-1:0] rd_word,
	output logic [INDEX_W-1:0] index,
	output logic [ADDR_W-INDEX_W-1:0] tag,
	output logic tag_write,
	output logic dirty_value,
	output logic data_write,
	output cache_ctrl_pkg::data_src_e data_src,
	output logic [DATA_W-1:0] fill_word,
	output logic [DATA_W-1:0] wr_word
);
	import cache_ctrl_pkg::*;

	localparam int TAG_W = ADDR_W - INDEX_W;

	cache_state_e state;
	cache_state_e next_state;

	logic req_we;
	logic cmp_ready;	// Tag store result is valid for the latched index.
	logic wb_done;		// Victim already written back in this transaction.
	logic mem_acked;	// DRAM ack seen, waiting for it to fall.
	logic mem_phase;
	logic [TAG_W-1:0] line_tag;

	assign mem_phase = (state == st_write_back) || (state == st_refill);

	// Next state.
	always_comb
	begin
		next_state = state;
		case (state)
			st_idle:
				if (cpu_req)
					next_state = st_compare;
			st_compare:
				if (cmp_ready)
				begin
					if (hit)
						next_state = req_we ? st_write_hit : st_respond;
					else if (victim_dirty && !wb_done)
						next_state = st_write_back;
					else if (req_we)
						next_state = st_write_hit;	// One-word line, nothing to fetch.
					else
						next_state = st_refill;
				end
			st_write_back:
				if (mem_acked && !mem_ack)
					next_state = st_compare;
			st_refill:
				if (mem_acked && !mem_ack)
					next_state = st_fill_write;
			st_fill_write:
				next_state = st_compare;
			st_write_hit:
				next_state = st_respond;
			st_respond:
				if (!cpu_req)
					next_state = st_idle;
			default:
				next_state = st_idle;
		endcase
	end

	// State and handshake tracking.
	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			state <= st_idle;
			cmp_ready <= 1'b0;
			wb_done <= 1'b0;
			mem_acked <= 1'b0;
		end
		else
		begin
			state <= next_state;
			cmp_ready <= (state == st_compare) && (next_state == st_compare);
			mem_acked <= mem_phase && (next_state == state) && (mem_acked || mem_ack);
			if (state == st_idle)
				wb_done <= 1'b0;
			else if ((state == st_write_back) && (next_state == st_compare))
				wb_done <= 1'b1;
		end
	end

	// Request is latched once, when it is accepted in idle.
	always_ff @(posedge clk)
	begin
		if ((state == st_idle) && cpu_req)
		begin
			req_we <= cpu_we;
			index <= cpu_addr[INDEX_W-1:0];
			tag <= cpu_addr[ADDR_W-1:INDEX_W];
			wr_word <= cpu_wdata;
		end
		// Fill word is taken while mem_ack is high.
		if ((state == st_refill) && mem_ack && !mem_acked)
			fill_word <= mem_rdata;
	end

	// Strobes decoded from the current state.
	always_comb
	begin
		cpu_ack = (state == st_respond);
		mem_req = mem_phase && !mem_acked;
		mem_we = (state == st_write_back);
		tag_write = (state == st_write_hit) || (state == st_fill_write);
		data_write = (state == st_write_hit) || (state == st_fill_write);
		dirty_value = (state == st_write_hit);
		data_src = (state == st_fill_write) ? src_mem : src_cpu;
	end

	// Write-back goes to the victim's address, a refill to the requested one.
	assign line_tag = (state == st_write_back) ? victim_tag : tag;
	assign mem_addr = {line_tag, index};

	// The indexed line still holds the victim during write-back.
	assign mem_wdata = rd_word;

endmodule

`default_nettype wire

// ==== design/cache_ctrl_pkg.sv ====
`default_nettype none

package cache_ctrl_pkg;

	// Controller states.
	// Compare waits one cycle for the tag store result before it decides.
	typedef enum logic [2:0] {
		st_idle,
		st_compare,
		st_write_back,
		st_refill,
		st_fill_write,
		st_write_hit,
		st_respond
	} cache_state_e;

	// Source of the word written into the data store.
	// CPU data on a write, DRAM data on a refill.
	typedef enum logic {
		src_cpu,
		src_mem
	} data_src_e;

endpackage

`default_nettype wire

// ==== design/cache_geom_pkg.sv ====
`default_nettype none

package cache_geom_pkg;

	// Word address width of both the CPU port and the DRAM port.
	// The DRAM holds one word per address, the same as the cache.
	localparam int addr_width_default = 16;

	// Width of one data word.
	// A cache line holds exactly one word.
	localparam int data_width_default = 32;

	// Index bits select the line.
	// Four bits give sixteen lines, direct mapped.
	// The tag is whatever remains of the address above the index.
	localparam int index_width_default = 4;

endpackage

`default_nettype wire

// ==== design/data_store.sv ====
`timescale 1ns/10ps
`default_nettype none

module data_store #(
	parameter int DATA_W = cache_geom_pkg::data_width_default,
	parameter int INDEX_W = cache_geom_pkg::index_width_default
) (
	input wire clk,
	input wire [INDEX_W-1:0] index,
	input wire data_write,
	input wire cache_ctrl_pkg::data_src_e data_src,
	input wire [DATA_W-1:0] wr_word,
	input wire [DATA_W-1:0] fill_word,
	output logic [DATA_W-1:0] rd_word
);
	import cache_ctrl_pkg::*;

	localparam int LINES = 1 << INDEX_W;

	logic [DATA_W-1:0] data_mem [LINES];
	logic [DATA_W-1:0] write_word;

	// CPU word on a write, DRAM word on a refill.
	assign write_word = (data_src == src_mem) ? fill_word : wr_word;

	always_ff @(posedge clk)
	begin
		if (data_write)
			data_mem[index] <= write_word;
	end

	// Registered read.
	// Serves both as CPU read data and as the victim word for write-back.
	always_ff @(posedge clk)
	begin
		rd_word <= data_mem[index];
	end

endmodule

`default_nettype wire

// ==== design/l1_cache.sv ====
`timescale 1ns/10ps
`default_nettype none

module l1_cache #(
	parameter int ADDR_W = cache_geom_pkg::addr_width_default,
	parameter int DATA_W = cache_geom_pkg::data_width_default,
	parameter int INDEX_W = cache_geom_pkg::index_width_default
) (
	input wire clk,
	input wire rst,

	// CPU side.
	input wire cpu_req,
	input wire cpu_we,
	input wire [ADDR_W-1:0] cpu_addr,
	input wire [DATA_W-1:0] cpu_wdata,
	output logic cpu_ack,
	output logic [DATA_W-1:0] cpu_rdata,

	// DRAM side.
	output logic mem_req,
	output logic mem_we,
	output logic [ADDR_W-1:0] mem_addr,
	output logic [DATA_W-1:0] mem_wdata,
	input wire mem_ack,
	input wire [DATA_W-1:0] mem_rdata
);
	import cache_ctrl_pkg::*;

	localparam int TAG_W = ADDR_W - INDEX_W;

	logic [INDEX_W-1:0] index;
	logic [TAG_W-1:0] tag;
	logic [TAG_W-1:0] victim_tag;
	logic hit;
	logic victim_dirty;
	logic tag_write;
	logic dirty_value;
	logic data_write;
	data_src_e data_src;
	logic [DATA_W-1:0] fill_word;
	logic [DATA_W-1:0] wr_word;

	cache_controller #(
		.ADDR_W(ADDR_W),
		.DATA_W(DATA_W),
		.INDEX_W(INDEX_W)
	) cache_controller_inst (
		.clk(clk),
		.rst(rst),
		.cpu_req(cpu_req),
		.cpu_we(cpu_we),
		.cpu_addr(cpu_addr),
		.cpu_wdata(cpu_wdata),
		.cpu_ack(cpu_ack),
		.mem_req(mem_req),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_ack(mem_ack),
		.mem_rdata(mem_rdata),
		.hit(hit),
		.victim_dirty(victim_dirty),
		.victim_tag(victim_tag),
		.rd_word(cpu_rdata),
		.index(index),
		.tag(tag),
		.tag_write(tag_write),
		.dirty_value(dirty_value),
		.data_write(data_write),
		.data_src(data_src),
		.fill_word(fill_word),
		.wr_word(wr_word)
	);

	tag_store #(
		.ADDR_W(ADDR_W),
		.INDEX_W(INDEX_W)
	) tag_store_inst (
		.clk(clk),
		.rst(rst),
		.index(index),
		.tag(tag),
		.tag_write(tag_write),
		.dirty_value(dirty_value),
		.hit(hit),
		.victim_dirty(victim_dirty),
		.victim_tag(victim_tag)
	);

	// Its read word is also the victim data for the controller.
	data_store #(
		.DATA_W(DATA_W),
		.INDEX_W(INDEX_W)
	) data_store_inst (
		.clk(clk),
		.index(index),
		.data_write(data_write),
		.data_src(data_src),
		.wr_word(wr_word),
		.fill_word(fill_word),
		.rd_word(cpu_rdata)
	);

endmodule

`default_nettype wire

// ==== design/tag_store.sv ====
`timescale 1ns/10ps
`default_nettype none

module tag_store #(
	parameter int ADDR_W = cache_geom_pkg::addr_width_default,
	parameter int INDEX_W = cache_geom_pkg::index_width_default
) (
	input wire clk,
	input wire rst,
	input wire [INDEX_W-1:0] index,
	input wire [ADDR_W-INDEX_W-1:0] tag,
	input wire tag_write,
	input wire dirty_value,
	output logic hit,
	output logic victim_dirty,
	output logic [ADDR_W-INDEX_W-1:0] victim_tag
);
	localparam int TAG_W = ADDR_W - INDEX_W;
	localparam int LINES = 1 << INDEX_W;

	logic [TAG_W-1:0] tag_mem [LINES];
	logic [LINES-1:0] valid;
	logic [LINES-1:0] dirty;

	// Every line starts invalid.
	always_ff @(posedge clk)
	begin
		if (!rst)
			valid <= '0;
		else if (tag_write)
			valid[index] <= 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (tag_write)
		begin
			tag_mem[index] <= tag;
			dirty[index] <= dirty_value;
		end
	end

	// Lookup result lags the index by one cycle.
	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			hit <= 1'b0;
			victim_dirty <= 1'b0;
		end
		else
		begin
			hit <= valid[index] && (tag_mem[index] == tag);
			victim_dirty <= valid[index] && dirty[index];
		end
	end

	// only meaningful when victim_dirty is set
	always_ff @(posedge clk)
	begin
		victim_tag <= tag_mem[index];
	end

endmodule

`default_nettype wire

// ==== l1_cache.f ====
design/cache_geom_pkg.sv
design/cache_ctrl_pkg.sv
design/cache_controller.sv
design/tag_store.sv
design/data_store.sv
design/l1_cache.sv
test/cache_checker.sv
test/tb_l1_cache.sv

// ==== test/cache_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module cache_checker #(
	parameter int ADDR_W = cache_geom_pkg::addr_width_default,
	parameter int DATA_W = cache_geom_pkg::data_width_default,
	parameter int INDEX_W = cache_geom_pkg::index_width_default
) (
	input wire clk,
	input wire rst,
	input wire cpu_req,
	input wire cpu_we,
	input wire [ADDR_W-1:0] cpu_addr,
	input wire [DATA_W-1:0] cpu_wdata,
	input wire cpu_ack,
	input wire [DATA_W-1:0] cpu_rdata,
	input wire mem_req,
	input wire mem_we,
	input wire [ADDR_W-1:0] mem_addr,
	input wire [DATA_W-1:0] mem_wdata
);
	localparam int tag_w = ADDR_W - INDEX_W;
	localparam int lines = 1 << INDEX_W;
	localparam logic [DATA_W-1:0] mem_pattern = 32'h5a5a0000;

	logic [DATA_W-1:0] ref_mem [1 << ADDR_W];
	logic [tag_w-1:0] shadow_tag [lines];
	logic [DATA_W-1:0] shadow_data [lines];
	logic [lines-1:0] shadow_valid;
	logic [lines-1:0] shadow_dirty;

	// Expected DRAM transfers in the order they must appear.
	logic exp_we [$];
	logic [ADDR_W-1:0] exp_addr [$];
	logic [DATA_W-1:0] exp_data [$];

	logic busy = 1'b0;
	logic cur_we;
	logic cur_hit;
	logic [DATA_W-1:0] exp_rdata;
	logic prev_ack = 1'b0;
	logic prev_req = 1'b0;
	logic prev_mem_req = 1'b0;
	logic after_reset = 1'b0;
	int cycle = 0;
	int start_cycle = 0;
	int error_count = 0;
	int test_errors = 0;
	int test_ops = 0;
	int total_ops = 0;
	int tests_passed = 0;
	int tests_failed = 0;

	initial
	begin : fill_reference
		int a;
		for (a = 0; a < (1 << ADDR_W); a++)
			ref_mem[a] = DATA_W'(a) ^ mem_pattern;
	end

	function automatic logic model_hits(input logic [ADDR_W-1:0] addr);
		logic [INDEX_W-1:0] idx;
		idx = addr[INDEX_W-1:0];
		return shadow_valid[idx] && (shadow_tag[idx] == addr[ADDR_W-1:INDEX_W]);
	endfunction

	// Runs one CPU access on the shadow cache and queues the DRAM traffic it implies.
	function automatic logic [DATA_W-1:0] model_access(input logic we,
			input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata);
		logic [INDEX_W-1:0] idx;
		logic [ADDR_W-1:0] victim_addr;
		idx = addr[INDEX_W-1:0];
		victim_addr = {shadow_tag[idx], idx};
		if (!model_hits(addr))
		begin
			if (shadow_valid[idx] && shadow_dirty[idx])
			begin
				exp_we.push_back(1'b1);
				exp_addr.push_back(victim_addr);
				exp_data.push_back(shadow_data[idx]);
				ref_mem[victim_addr] = shadow_data[idx];
			end
			// A one-word line is fetched on a read miss only.
			if (!we)
			begin
				exp_we.push_back(1'b0);
				exp_addr.push_back(addr);
				exp_data.push_back(ref_mem[addr]);
			end
			shadow_tag[idx] = addr[ADDR_W-1:INDEX_W];
			shadow_valid[idx] = 1'b1;
			shadow_dirty[idx] = 1'b0;
			shadow_data[idx] = ref_mem[addr];
		end
		if (we)
		begin
			shadow_data[idx] = wdata;
			shadow_dirty[idx] = 1'b1;
		end
		return shadow_data[idx];
	endfunction

	task automatic report_mismatch(input string name, input logic [DATA_W-1:0] expected,
			input logic [DATA_W-1:0] actual);
		$display("ERR %0t %s expected %0h actual %0h", $time, name, expected, actual);
		error_count++;
		test_errors++;
	endtask

	task automatic report_problem(input string text);
		$display("%0t: %s", $time, text);
		error_count++;
		test_errors++;
	endtask

	// Inputs change on the falling edge, so the rising edge sees settled values.
	always @(posedge clk)
	begin : watch
		int latency;
		logic w;
		logic [ADDR_W-1:0] a;
		logic [DATA_W-1:0] d;
		cycle++;
		if (!rst)
		begin
			shadow_valid = '0;
			shadow_dirty = '0;
			busy = 1'b0;
			exp_we.delete();
			exp_addr.delete();
			exp_data.delete();
			after_reset = 1'b1;
		end
		else
		begin
			if (after_reset && ((cpu_ack !== 1'b0) || (mem_req !== 1'b0)))
				report_problem("cpu_ack or mem_req is not low after reset");
			after_reset = 1'b0;
			if (cpu_ack && !prev_ack && !prev_req)
				report_problem("cpu_ack rose while cpu_req was low");
			if (!cpu_ack && prev_ack && prev_req)
				report_problem("cpu_ack fell while cpu_req was still high");
			if (mem_req && !prev_mem_req)
			begin
				if (exp_we.size() == 0)
					report_problem($sformatf("unexpected DRAM request to %0h", mem_addr));
				else
				begin
					w = exp_we.pop_front();
					a = exp_addr.pop_front();
					d = exp_data.pop_front();
					if (mem_we !== w)
						report_mismatch("mem_we", DATA_W'(w), DATA_W'(mem_we));
					if (mem_addr !== a)
						report_mismatch("mem_addr", DATA_W'(a), DATA_W'(mem_addr));
					if (w && (mem_wdata !== d))
						report_mismatch("mem_wdata", d, mem_wdata);
				end
			end
			if (cpu_ack && !prev_ack && busy)
			begin
				if (exp_we.size() != 0)
					report_problem($sformatf("%0d expected DRAM transfers never happened",
						exp_we.size()));
				exp_we.delete();
				exp_addr.delete();
				exp_data.delete();
				if (!cur_we && (cpu_rdata !== exp_rdata))
					report_mismatch("cpu_rdata", exp_rdata, cpu_rdata);
				// The ack seen here was set by the previous edge.
				latency = cycle - 1 - start_cycle;
				if (cur_hit && (latency != (cur_we ? 3 : 2)))
					report_problem($sformatf("hit took %0d cycles to cpu_ack", latency));
				busy = 1'b0;
				test_ops++;
				total_ops++;
			end
			if (cpu_req && !busy && !cpu_ack)
			begin
				busy = 1'b1;
				cur_we = cpu_we;
				cur_hit = model_hits(cpu_addr);
				exp_rdata = model_access(cpu_we, cpu_addr, cpu_wdata);
				start_cycle = cycle;
			end
		end
		prev_ack = cpu_ack;
		prev_req = cpu_req;
		prev_mem_req = mem_req;
	end

	task automatic finish_test(input string name);
		if (busy || (exp_we.size() != 0))
			report_problem($sformatf("test %s ended with a transaction still open", name));
		if (test_errors == 0)
		begin
			tests_passed++;
			$display("test %s: pass, %0d accesses", name, test_ops);
		end
		else
		begin
			tests_failed++;
			$display("test %s: FAIL, %0d errors in %0d accesses", name, test_errors, test_ops);
		end
		test_errors = 0;
		test_ops = 0;
	endtask

	task automatic report_counts();
		$display("%0d tests passed, %0d failed, %0d accesses, %0d errors",
			tests_passed, tests_failed, total_ops, error_count);
	endtask

endmodule

`default_nettype wire

// ==== test/tb_l1_cache.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_l1_cache;
	import cache_geom_pkg::*;

	localparam int ADDR_W = addr_width_default;
	localparam int DATA_W = data_width_default;
	localparam int INDEX_W = index_width_default;
	localparam logic [DATA_W-1:0] mem_pattern = 32'h5a5a0000;
	localparam int random_ops = 200;
	// First reads, repeated reads, write and read pairs, conflict pairs, random mix.
	localparam int total_ops = 16 + 16 + 16 + 8 + random_ops;
	localparam int timeout_cycles = total_ops * 40;

	logic clk;
	logic rst;
	logic cpu_req;
	logic cpu_we;
	logic [ADDR_W-1:0] cpu_addr;
	logic [DATA_W-1:0] cpu_wdata;
	logic cpu_ack;
	logic [DATA_W-1:0] cpu_rdata;
	logic mem_req;
	logic mem_we;
	logic [ADDR_W-1:0] mem_addr;
	logic [DATA_W-1:0] mem_wdata;
	logic mem_ack;
	logic [DATA_W-1:0] mem_rdata;

	logic [DATA_W-1:0] dram [1 << ADDR_W];
	integer seed = 32'hce3d;
	int cycles = 0;

	l1_cache #(
		.ADDR_W(ADDR_W),
		.DATA_W(DATA_W),
		.INDEX_W(INDEX_W)
	) l1_cache_inst (
		.clk(clk),
		.rst(rst),
		.cpu_req(cpu_req),
		.cpu_we(cpu_we),
		.cpu_addr(cpu_addr),
		.cpu_wdata(cpu_wdata),
		.cpu_ack(cpu_ack),
		.cpu_rdata(cpu_rdata),
		.mem_req(mem_req),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_ack(mem_ack),
		.mem_rdata(mem_rdata)
	);

	cache_checker #(
		.ADDR_W(ADDR_W),
		.DATA_W(DATA_W),
		.INDEX_W(INDEX_W)
	) checker_inst (
		.clk(clk),
		.rst(rst),
		.cpu_req(cpu_req),
		.cpu_we(cpu_we),
		.cpu_addr(cpu_addr),
		.cpu_wdata(cpu_wdata),
		.cpu_ack(cpu_ack),
		.cpu_rdata(cpu_rdata),
		.mem_req(mem_req),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial
	begin
		while (cycles < timeout_cycles)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: no end of the run within %0d cycles.", timeout_cycles);
		$display("Test failed");
		$finish;
	end

	// DRAM model that acks each request after 1 to 4 cycles.
	initial
	begin : dram_model
		int a;
		int wait_cycles;
		mem_ack = 1'b0;
		mem_rdata = '0;
		for (a = 0; a < (1 << ADDR_W); a++)
			dram[a] = DATA_W'(a) ^ mem_pattern;
		forever
		begin
			@(negedge clk);
			if (mem_req === 1'b1)
			begin
				wait_cycles = 1 + ({$random(seed)} % 4);
				repeat (wait_cycles) @(negedge clk);
				if (mem_we)
					dram[mem_addr] = mem_wdata;
				else
					mem_rdata = dram[mem_addr];
				mem_ack = 1'b1;
				while (mem_req)
					@(negedge clk);
				mem_ack = 1'b0;
			end
		end
	end

	// One four-phase CPU access that drops req a few cycles after ack.
	task automatic cpu_access(input logic we, input logic [ADDR_W-1:0] addr,
			input logic [DATA_W-1:0] wdata, input int drop_delay);
		@(negedge clk);
		cpu_we = we;
		cpu_addr = addr;
		cpu_wdata = wdata;
		cpu_req = 1'b1;
		do
			@(negedge clk);
		while (!cpu_ack);
		repeat (drop_delay) @(negedge clk);
		cpu_req = 1'b0;
		do
			@(negedge clk);
		while (cpu_ack);
	endtask

	initial
	begin : stimulus
		int i;
		logic [31:0] rnd_we;
		logic [31:0] rnd_addr;
		logic [31:0] rnd_data;
		int drop;
		rst = 1'b0;
		cpu_req = 1'b0;
		cpu_we = 1'b0;
		cpu_addr = '0;
		cpu_wdata = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b1;

		for (i = 0; i < 16; i++)
			cpu_access(1'b0, ADDR_W'(16'h0120 + i), '0, 0);
		checker_inst.finish_test("first reads miss once");

		for (i = 0; i < 16; i++)
			cpu_access(1'b0, ADDR_W'(16'h0120 + i), '0, 1);
		checker_inst.finish_test("repeated reads hit");

		for (i = 0; i < 8; i++)
		begin
			rnd_data = $random(seed);
			cpu_access(1'b1, ADDR_W'(16'h0120 + i), rnd_data, 0);
			cpu_access(1'b0, ADDR_W'(16'h0120 + i), '0, 2);
		end
		checker_inst.finish_test("write hit then read");

		// Lines 8 to 11 are clean, so the first write of a pair evicts without a write-back.
		for (i = 8; i < 12; i++)
		begin
			rnd_data = $random(seed);
			cpu_access(1'b1, ADDR_W'(16'h0a30 + i), rnd_data, 1);
			cpu_access(1'b0, ADDR_W'(16'h0b30 + i), '0, 0);
		end
		checker_inst.finish_test("dirty eviction order");

		// Four tags per line keep the random mix full of conflicts.
		for (i = 0; i < random_ops; i++)
		begin
			rnd_we = $random(seed);
			rnd_addr = $random(seed);
			rnd_data = $random(seed);
			drop = {$random(seed)} % 4;
			cpu_access(rnd_we[0], ADDR_W'(rnd_addr[5:0]), rnd_data, drop);
		end
		checker_inst.finish_test("random mixed traffic");

		checker_inst.report_counts();
		if (checker_inst.error_count == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire
